// ==== Makefile ====
TOOL       = verilator
TOP        = tb_iopage
FILELIST   = list.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = ** PASS **
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@grep -qF -- "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/clk_regs.sv ====
`timescale 1ns/100ps
// line-clock status register; only bit 7 (monitor) and bit 6 (enable) exist
// line_tick must be a one-cycle strobe already in the clk domain
module clk_regs
   import iopage_pkg::*;
#(
   parameter logic [IOP_AW-1:0] OFFSET = LKS_OFFSET,
   parameter logic [7:0]        VECTOR = LKS_VECTOR
)
(
   input  logic              clk,
   input  logic              arst_n,
   input  logic [IOP_AW-1:0] iopage_addr,
   input  logic [IOP_DW-1:0] data_in,
   input  logic              iopage_rd,
   input  logic              iopage_wr,
   input  logic              iopage_byte_op,
   input  logic              line_tick,
   input  logic              interrupt_ack,
   output logic [IOP_DW-1:0] rdata,
   output logic              decode,
   output logic              interrupt,
   output logic [7:0]        vector
);

   iop_op_e op;
   logic    hit;
   logic    wr_lo;
   logic    monitor;
   logic    enable;
   logic    request;

   assign op  = iop_op(iopage_rd, iopage_wr, iopage_byte_op);
   assign hit = iopage_addr[IOP_AW-1:1] == OFFSET[IOP_AW-1:1];

   assign decode = hit && (op != op_idle);

   // both status bits sit in the low byte, high byte writes are dropped
   assign wr_lo = decode &&
                  ((op == op_write_word) || ((op == op_write_byte) && !iopage_addr[0]));

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         monitor <= 1'b0;
         enable  <= 1'b0;
      end
      else
      begin
         // tick wins over a software write
         if (line_tick)
            monitor <= 1'b1;
         else if (wr_lo)
            monitor <= data_in[7];
         if (wr_lo)
            enable <= data_in[6];
      end
   end

   // pending request, a tick beats an ack in the same cycle
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         request <= 1'b0;
      else if (wr_lo && !data_in[6])
         request <= 1'b0;
      else if (line_tick && enable)
         request <= 1'b1;
      else if (interrupt_ack)
         request <= 1'b0;
   end

   assign rdata = decode ? {{(IOP_DW-8){1'b0}}, monitor, enable, 6'b00_0000} : '0;

   assign interrupt = request;
   assign vector    = request ? VECTOR : 8'h00;

   req_needs_enable: assert property (@(posedge clk) disable iff (!arst_n)
      request |-> enable)
      else $error("line clock request pending with enable clear");

   rd_wr_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
      !(iopage_rd && iopage_wr))
      else $error("read and write strobes high together");

endmodule

// ==== design/iopage.sv ====
`timescale 1ns/100ps
// i/o page top; the cpu has already qualified the top 8 KB, only address[12:0]
// is decoded. accesses are level strobes and reads return data in the same cycle
module iopage
   import iopage_pkg::*;
#(
   parameter logic [IOP_AW-1:0] LKS_OFFSET_P = LKS_OFFSET,
   parameter logic [IOP_AW-1:0] SR_OFFSET_P  = SR_OFFSET,
   parameter logic [7:0]        LKS_VECTOR_P = LKS_VECTOR
)
(
   input  logic              clk,
   input  logic              arst_n,
   input  logic [21:0]       address,
   input  logic [IOP_DW-1:0] data_in,
   input  logic              iopage_rd,
   input  logic              iopage_wr,
   input  logic              iopage_byte_op,
   input  logic [7:0]        ack_ipl,
   input  logic [IOP_DW-1:0] switches,
   input  logic              line_tick,
   output logic [IOP_DW-1:0] data_out,
   output logic              no_decode,
   output logic              interrupt,
   output logic [7:0]        interrupt_ipl,
   output logic [7:0]        vector,
   output logic [IOP_DW-1:0] display
);

   logic [IOP_AW-1:0] iopage_addr;
   logic              lks_decode;
   logic [IOP_DW-1:0] lks_rdata;
   logic              lks_interrupt;
   logic [7:0]        lks_vector;
   logic              sr_decode;
   logic [IOP_DW-1:0] sr_rdata;

   assign iopage_addr = address[IOP_AW-1:0];

   clk_regs #(
      .OFFSET (LKS_OFFSET_P),
      .VECTOR (LKS_VECTOR_P)
   ) i_clk_regs (
      .clk            (clk),
      .arst_n         (arst_n),
      .iopage_addr    (iopage_addr),
      .data_in        (data_in),
      .iopage_rd      (iopage_rd),
      .iopage_wr      (iopage_wr),
      .iopage_byte_op (iopage_byte_op),
      .line_tick      (line_tick),
      .interrupt_ack  (ack_ipl[LKS_IPL_BIT]),
      .rdata          (lks_rdata),
      .decode         (lks_decode),
      .interrupt      (lks_interrupt),
      .vector         (lks_vector)
   );

   sr_regs #(
      .OFFSET (SR_OFFSET_P)
   ) i_sr_regs (
      .clk            (clk),
      .arst_n         (arst_n),
      .iopage_addr    (iopage_addr),
      .data_in        (data_in),
      .iopage_rd      (iopage_rd),
      .iopage_wr      (iopage_wr),
      .iopage_byte_op (iopage_byte_op),
      .switches       (switches),
      .rdata          (sr_rdata),
      .decode         (sr_decode),
      .display        (display)
   );

   iopage_mux i_iopage_mux (
      .iopage_rd     (iopage_rd),
      .iopage_wr     (iopage_wr),
      .lks_decode    (lks_decode),
      .lks_rdata     (lks_rdata),
      .sr_decode     (sr_decode),
      .sr_rdata      (sr_rdata),
      .lks_interrupt (lks_interrupt),
      .lks_vector    (lks_vector),
      .data_out      (data_out),
      .no_decode     (no_decode),
      .interrupt     (interrupt),
      .interrupt_ipl (interrupt_ipl),
      .vector        (vector)
   );

endmodule

// ==== design/iopage_mux.sv ====
`timescale 1ns/100ps
// read data select, no_decode and interrupt merge for the i/o page
// the line clock is the only interrupt source, at level 6
module iopage_mux
   import iopage_pkg::*;
(
   input  logic              iopage_rd,
   input  logic              iopage_wr,
   input  logic              lks_decode,
   input  logic [IOP_DW-1:0] lks_rdata,
   input  logic              sr_decode,
   input  logic [IOP_DW-1:0] sr_rdata,
   input  logic              lks_interrupt,
   input  logic [7:0]        lks_vector,
   output logic [IOP_DW-1:0] data_out,
   output logic              no_decode,
   output logic              interrupt,
   output logic [7:0]        interrupt_ipl,
   output logic [7:0]        vector
);

   iop_dev_e dev;

   // which device claimed this access
   always_comb
   begin
      if (lks_decode)
         dev = dev_lks;
      else if (sr_decode)
         dev = dev_sr;
      else
         dev = dev_none;
   end

   always_comb
   begin
      case (dev)
         dev_lks: data_out = lks_rdata;
         dev_sr:  data_out = sr_rdata;
         default: data_out = '0;
      endcase
   end

   assign no_decode = (iopage_rd || iopage_wr) && (dev == dev_none);

   // one bit per priority level, highest level at the top
   always_comb
   begin
      interrupt_ipl = 8'h00;
      interrupt_ipl[LKS_IPL_BIT] = lks_interrupt;
   end

   assign interrupt = |interrupt_ipl;

   // vector of the highest pending level
   always_comb
   begin
      if (interrupt_ipl[LKS_IPL_BIT])
         vector = lks_vector;
      else
         vector = 8'h00;
   end

   // offsets overlapping would mean two devices drive the bus
   always_comb
   begin
      if (iopage_rd || iopage_wr)
      begin
         one_claim: assert ($onehot0({lks_decode, sr_decode}))
            else $error("more than one device decoded, %s selected", dev.name());
      end
   end

endmodule

// ==== design/iopage_pkg.sv ====
// offsets are 13-bit octal page offsets; device decode ignores bit 0,
// which only selects the byte lane of a byte write
package iopage_pkg;

   localparam int IOP_AW = 13;
   localparam int IOP_DW = 16;

   localparam logic [IOP_AW-1:0] LKS_OFFSET = 13'o7546;
   localparam logic [IOP_AW-1:0] SR_OFFSET  = 13'o7570;

   localparam logic [7:0] LKS_VECTOR  = 8'o100;
   localparam int         LKS_IPL_BIT = 6;

   typedef enum logic [1:0] {dev_none, dev_lks, dev_sr} iop_dev_e;

   typedef enum logic [1:0] {op_idle, op_read, op_write_word, op_write_byte} iop_op_e;

   // read wins if the cpu ever drives both strobes
   function automatic iop_op_e iop_op(input logic rd, input logic wr, input logic byte_op);
      iop_op_e op;
      if (rd)
         op = op_read;
      else if (wr && byte_op)
         op = op_write_byte;
      else if (wr)
         op = op_write_word;
      else
         op = op_idle;
      return op;
   endfunction

endpackage

// ==== design/sr_regs.sv ====
`timescale 1ns/100ps
// switch register on read, display register on write at the same offset
// the display register cannot be read back, display is its only view
module sr_regs
   import iopage_pkg::*;
#(
   parameter logic [IOP_AW-1:0] OFFSET = SR_OFFSET
)
(
   input  logic              clk,
   input  logic              arst_n,
   input  logic [IOP_AW-1:0] iopage_addr,
   input  logic [IOP_DW-1:0] data_in,
   input  logic              iopage_rd,
   input  logic              iopage_wr,
   input  logic              iopage_byte_op,
   input  logic [IOP_DW-1:0] switches,
   output logic [IOP_DW-1:0] rdata,
   output logic              decode,
   output logic [IOP_DW-1:0] display
);

   iop_op_e op;
   logic    hit;
   logic    wr_lo;
   logic    wr_hi;

   assign op  = iop_op(iopage_rd, iopage_wr, iopage_byte_op);
   assign hit = iopage_addr[IOP_AW-1:1] == OFFSET[IOP_AW-1:1];

   assign decode = hit && (op != op_idle);

   // byte lane from address bit 0
   assign wr_lo = decode &&
                  ((op == op_write_word) || ((op == op_write_byte) && !iopage_addr[0]));
   assign wr_hi = decode &&
                  ((op == op_write_word) || ((op == op_write_byte) && iopage_addr[0]));

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         display <= '0;
      else
      begin
         if (wr_lo)
            display[7:0] <= data_in[7:0];
         // high byte always comes from the upper data lane
         if (wr_hi)
            display[15:8] <= data_in[15:8];
      end
   end

   assign rdata = decode ? switches : '0;

   rd_wr_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
      !(iopage_rd && iopage_wr))
      else $error("read and write strobes high together");

endmodule

// ==== list.f ====
design/iopage_pkg.sv
design/clk_regs.sv
design/sr_regs.sv
design/iopage_mux.sv
design/iopage.sv
testbench/tb_clock_gen.sv
testbench/tb_iopage.sv

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/100ps
// free-running clock and active-low reset for the testbench
// reset releases 1 ns after the last reset edge
module tb_clock_gen #(
   parameter int PERIOD       = 8,
   parameter int RESET_CYCLES = 4
)
(
   output logic clk,
   output logic arst_n
);

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD/2) clk = ~clk;
   end

   initial
   begin
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      arst_n = 1'b1;
   end

endmodule

// ==== testbench/tb_iopage.sv ====
`timescale 1ns/100ps
// self-checking testbench for the i/o page; inputs change 1 ns after the rising edge,
// outputs are compared and the model steps at the falling edge
module tb_iopage;

   localparam int          CLK_PERIOD   = 8;
   localparam int          RESET_CYCLES = 4;
   localparam logic [12:0] LKS_ADDR     = 13'o7546;
   localparam logic [12:0] SR_ADDR      = 13'o7570;
   localparam logic [7:0]  LKS_VEC      = 8'o100;

   localparam int N_SR_READS     = 8;
   localparam int N_DISP_WRITES  = 12;
   localparam int N_STATUS_STEPS = 16;
   localparam int N_IRQ_STEPS    = 28;
   localparam int N_UNCLAIMED    = 40;
   localparam int N_MIXED        = 80;
   localparam int PLANNED_ACCESSES = 2 * N_SR_READS + 2 * N_DISP_WRITES + N_STATUS_STEPS +
                                     N_IRQ_STEPS + N_UNCLAIMED + N_MIXED + 8;
   localparam int WATCHDOG_NS = (PLANNED_ACCESSES + RESET_CYCLES) * 10 * CLK_PERIOD;

   typedef struct packed {
      logic [15:0] data_out;
      logic        no_decode;
      logic        interrupt;
      logic [7:0]  interrupt_ipl;
      logic [7:0]  vector;
      logic [15:0] display;
   } expect_t;

   logic        clk;
   logic        arst_n;
   logic [21:0] address;
   logic [15:0] data_in;
   logic        iopage_rd;
   logic        iopage_wr;
   logic        iopage_byte_op;
   logic [7:0]  ack_ipl;
   logic [15:0] switches;
   logic        line_tick;
   logic [15:0] data_out;
   logic        no_decode;
   logic        interrupt;
   logic [7:0]  interrupt_ipl;
   logic [7:0]  vector;
   logic [15:0] display;

   // reference state
   logic [15:0] m_display;
   logic        m_monitor;
   logic        m_enable;
   logic        m_request;

   integer seed;
   int     irq_cycles;
   int     unclaimed_cycles;

   tb_clock_gen #(
      .PERIOD       (CLK_PERIOD),
      .RESET_CYCLES (RESET_CYCLES)
   ) i_clock_gen (
      .clk    (clk),
      .arst_n (arst_n)
   );

   iopage i_iopage (
      .clk            (clk),
      .arst_n         (arst_n),
      .address        (address),
      .data_in        (data_in),
      .iopage_rd      (iopage_rd),
      .iopage_wr      (iopage_wr),
      .iopage_byte_op (iopage_byte_op),
      .ack_ipl        (ack_ipl),
      .switches       (switches),
      .line_tick      (line_tick),
      .data_out       (data_out),
      .no_decode      (no_decode),
      .interrupt      (interrupt),
      .interrupt_ipl  (interrupt_ipl),
      .vector         (vector),
      .display        (display)
   );

   // expected outputs for the current inputs and reference state
   function automatic expect_t reference_outputs(input logic [12:0] off, input logic rd,
                                                 input logic wr, input logic [15:0] sw,
                                                 input logic [15:0] disp, input logic mon,
                                                 input logic en, input logic req);
      expect_t e;
      logic    at_lks;
      logic    at_sr;
      at_lks = off[12:1] == LKS_ADDR[12:1];
      at_sr  = off[12:1] == SR_ADDR[12:1];
      e = '0;
      if ((rd || wr) && at_lks)
         e.data_out = {8'h00, mon, en, 6'b00_0000};
      else if ((rd || wr) && at_sr)
         e.data_out = sw;
      e.no_decode     = (rd || wr) && !at_lks && !at_sr;
      e.interrupt     = req;
      e.interrupt_ipl = {1'b0, req, 6'b00_0000};
      e.vector        = req ? LKS_VEC : 8'h00;
      e.display       = disp;
      return e;
   endfunction

   // state the dut should hold after the coming rising edge
   task automatic advance_model(input logic [12:0] off, input logic wr, input logic byte_op,
                                input logic [15:0] data, input logic tick, input logic ack);
      logic lo_lane;
      logic hi_lane;
      logic at_lks;
      logic next_req;
      lo_lane  = wr && (!byte_op || !off[0]);
      hi_lane  = wr && (!byte_op || off[0]);
      at_lks   = off[12:1] == LKS_ADDR[12:1];
      next_req = m_request;
      if (off[12:1] == SR_ADDR[12:1])
      begin
         if (lo_lane)
            m_display[7:0] = data[7:0];
         if (hi_lane)
            m_display[15:8] = data[15:8];
      end
      if (at_lks && lo_lane && !data[6])
         next_req = 1'b0;
      else if (tick && m_enable)
         next_req = 1'b1;
      else if (ack)
         next_req = 1'b0;
      if (at_lks && lo_lane)
      begin
         m_monitor = data[7];
         m_enable  = data[6];
      end
      if (tick)
         m_monitor = 1'b1;
      m_request = next_req;
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected)
      begin
         $display("mismatch %s: got %h, expected %h at %0t ns", name, actual, expected, $time);
         $display("** FAIL **");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   always @(negedge clk)
   begin : compare_outputs
      expect_t e;
      if (arst_n !== 1'b1)
      begin
         m_display = '0;
         m_monitor = 1'b0;
         m_enable  = 1'b0;
         m_request = 1'b0;
      end
      else
      begin
         e = reference_outputs(address[12:0], iopage_rd, iopage_wr, switches,
                               m_display, m_monitor, m_enable, m_request);
         check_value("data_out", 32'(data_out), 32'(e.data_out));
         check_value("no_decode", 32'(no_decode), 32'(e.no_decode));
         check_value("interrupt", 32'(interrupt), 32'(e.interrupt));
         check_value("interrupt_ipl", 32'(interrupt_ipl), 32'(e.interrupt_ipl));
         check_value("vector", 32'(vector), 32'(e.vector));
         check_value("display", 32'(display), 32'(e.display));
         if (interrupt)
            irq_cycles++;
         if (no_decode)
            unclaimed_cycles++;
         advance_model(address[12:0], iopage_wr, iopage_byte_op, data_in, line_tick,
                       ack_ipl[6]);
      end
   end

   // one bus cycle, new switch value every cycle
   task automatic drive_cycle(input logic rd, input logic wr, input logic byte_op,
                              input logic [12:0] off, input logic [15:0] data,
                              input logic tick, input logic [7:0] ack);
      logic [31:0] rnd;
      @(posedge clk);
      #1;
      rnd            = $random(seed);
      address        = {9'h1ff, off};
      data_in        = data;
      iopage_rd      = rd;
      iopage_wr      = wr;
      iopage_byte_op = byte_op;
      line_tick      = tick;
      ack_ipl        = ack;
      switches       = rnd[15:0];
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) drive_cycle(1'b0, 1'b0, 1'b0, 13'h0000, 16'h0000, 1'b0, 8'h00);
   endtask

   task automatic read_reg(input logic [12:0] off);
      drive_cycle(1'b1, 1'b0, 1'b0, off, 16'h0000, 1'b0, 8'h00);
   endtask

   task automatic write_word(input logic [12:0] off, input logic [15:0] data);
      drive_cycle(1'b0, 1'b1, 1'b0, off, data, 1'b0, 8'h00);
   endtask

   task automatic write_byte(input logic [12:0] off, input logic [15:0] data);
      drive_cycle(1'b0, 1'b1, 1'b1, off, data, 1'b0, 8'h00);
   endtask

   task automatic pulse_tick();
      drive_cycle(1'b0, 1'b0, 1'b0, 13'h0000, 16'h0000, 1'b1, 8'h00);
   endtask

   task automatic pulse_ack(input logic [7:0] ack);
      drive_cycle(1'b0, 1'b0, 1'b0, 13'h0000, 16'h0000, 1'b0, ack);
   endtask

   // half of them land near the device registers
   task automatic pick_unclaimed(output logic [12:0] off);
      logic [31:0] rnd;
      rnd = $random(seed);
      off = rnd[12:0];
      if (rnd[20])
         off = 13'o7500 | {7'h00, rnd[5:0]};
      while ((off[12:1] == LKS_ADDR[12:1]) || (off[12:1] == SR_ADDR[12:1]))
      begin
         rnd = $random(seed);
         off = rnd[12:0];
      end
   endtask

   task automatic switch_reads();
      repeat (N_SR_READS)
      begin
         read_reg(SR_ADDR);
         idle_cycles(1);
      end
      read_reg(SR_ADDR | 13'd1);
   endtask

   task automatic display_writes();
      logic [31:0] rnd;
      for (int i = 0; i < N_DISP_WRITES; i++)
      begin
         rnd = $random(seed);
         case (i % 3)
            0: write_word(SR_ADDR, rnd[15:0]);
            1: write_byte(SR_ADDR, rnd[15:0]);
            default: write_byte(SR_ADDR | 13'd1, rnd[15:0]);
         endcase
         read_reg(SR_ADDR);
      end
   endtask

   task automatic status_writes();
      write_word(LKS_ADDR, 16'h0040);
      read_reg(LKS_ADDR);
      write_word(LKS_ADDR, 16'h0000);
      read_reg(LKS_ADDR);
      // monitor set, enable clear
      pulse_tick();
      idle_cycles(1);
      read_reg(LKS_ADDR);
      write_word(LKS_ADDR, 16'h0040);
      read_reg(LKS_ADDR);
      write_word(LKS_ADDR, 16'hffff);
      read_reg(LKS_ADDR);
      // upper lane holds no status bits
      write_byte(LKS_ADDR | 13'd1, 16'h0000);
      read_reg(LKS_ADDR);
      write_byte(LKS_ADDR, 16'hff00);
      read_reg(LKS_ADDR);
   endtask

   task automatic interrupt_sequence();
      write_word(LKS_ADDR, 16'h0040);
      pulse_tick();
      idle_cycles(3);
      read_reg(LKS_ADDR);
      // other levels leave the line clock pending
      pulse_ack(8'h20);
      pulse_ack(8'h40);
      idle_cycles(2);
      pulse_tick();
      idle_cycles(2);
      write_word(LKS_ADDR, 16'h0000);
      idle_cycles(2);
      pulse_tick();
      idle_cycles(2);
      write_word(LKS_ADDR, 16'h0040);
      pulse_tick();
      drive_cycle(1'b0, 1'b0, 1'b0, 13'h0000, 16'h0000, 1'b1, 8'h40);
      idle_cycles(2);
      pulse_ack(8'h40);
      idle_cycles(2);
   endtask

   task automatic unclaimed_accesses();
      logic [31:0] rnd;
      logic [12:0] off;
      for (int i = 0; i < N_UNCLAIMED; i++)
      begin
         pick_unclaimed(off);
         rnd = $random(seed);
         case (rnd[17:16])
            2'd0: read_reg(off);
            2'd1: write_word(off, rnd[15:0]);
            2'd2: write_byte(off, rnd[15:0]);
            default: idle_cycles(1);
         endcase
      end
   endtask

   task automatic mixed_traffic();
      logic [31:0] rnd;
      logic [31:0] rnd_data;
      logic [12:0] off;
      logic        rd;
      logic        wr;
      logic        tick;
      logic [7:0]  ack;
      for (int i = 0; i < N_MIXED; i++)
      begin
         rnd      = $random(seed);
         rnd_data = $random(seed);
         case (rnd[2:0])
            3'd0, 3'd1: off = LKS_ADDR;
            3'd2: off = LKS_ADDR | 13'd1;
            3'd3, 3'd4: off = SR_ADDR;
            3'd5: off = SR_ADDR | 13'd1;
            default: pick_unclaimed(off);
         endcase
         rd = rnd[4:3] == 2'd0;
         wr = (rnd[4:3] == 2'd1) || (rnd[4:3] == 2'd2);
         // no tick during a status write
         tick = (rnd[8:6] == 3'd0) && !(wr && (off[12:1] == LKS_ADDR[12:1]));
         if (rnd[11:9] == 3'd0)
            ack = 8'h40;
         else if (rnd[11:9] == 3'd1)
            ack = 8'h01 << rnd[14:12];
         else
            ack = 8'h00;
         drive_cycle(rd, wr, rnd[5], off, rnd_data[15:0], tick, ack);
      end
   endtask

   initial
   begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, test sequence did not finish", WATCHDOG_NS);
      $display("** FAIL **");
      $fatal(1, "timeout");
   end

   initial
   begin
      seed             = 32'h5a4a_58f1;
      irq_cycles       = 0;
      unclaimed_cycles = 0;
      address          = '0;
      data_in          = '0;
      iopage_rd        = 1'b0;
      iopage_wr        = 1'b0;
      iopage_byte_op   = 1'b0;
      ack_ipl          = '0;
      switches         = '0;
      line_tick        = 1'b0;
      wait (arst_n === 1'b1);
      switch_reads();
      display_writes();
      status_writes();
      interrupt_sequence();
      unclaimed_accesses();
      mixed_traffic();
      idle_cycles(4);
      if ((irq_cycles == 0) || (unclaimed_cycles == 0))
      begin
         $display("stimulus never raised an interrupt or an unclaimed access");
         $display("** FAIL **");
         $fatal(1, "stimulus incomplete");
      end
      else
      begin
         $display("** PASS **");
         $finish;
      end
   end

endmodule
